//--- verilog.f
logic/array_pkg.sv
logic/host_session.sv
logic/sd_transfer.sv
logic/block_walker.sv
logic/cmd_sequencer.sv
logic/array_ctrl_top.sv
sim/sd_card_model.sv
sim/array_ctrl_tb.sv

//--- Makefile
SRCS := $(shell grep -v '^+' verilog.f)

obj_dir/Varray_ctrl_tb: verilog.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module array_ctrl_tb -f verilog.f

run: obj_dir/Varray_ctrl_tb
	./obj_dir/Varray_ctrl_tb | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- sim/array_ctrl_tb.sv
`timescale 1ns/1ps

module array_ctrl_tb;

	localparam int N_ROWS = 11;
	localparam int MAX_DELAY = 8;	// worst cycles per sd word
	localparam int LIMIT = N_ROWS * array_pkg::CLEAR_BLOCKS * array_pkg::BLOCK_WORDS *
		MAX_DELAY + 2000;

	typedef struct packed {
		logic [2:0] op;
		logic [array_pkg::BLOCK_NO_W-1:0] blk;
		logic rd;
		logic [array_pkg::WORD_IDX_W-1:0] len;
		logic [array_pkg::WORD_IDX_W-1:0] off;
		logic miss;
		logic [array_pkg::SD_ERR_W-1:0] err;
		logic [2:0] kind;
	} cmd_t;

	logic clk;
	logic n_rst;
	logic ahb_ready;
	logic [2:0] op_code;
	logic [array_pkg::BLOCK_NO_W-1:0] ahb_block_no;
	logic mode;
	logic [array_pkg::WORD_IDX_W-1:0] ahb_length;
	logic [array_pkg::WORD_IDX_W-1:0] ahb_offset;
	logic ahb_start;
	logic ahb_done;
	logic [array_pkg::SD_ERR_W+2:0] status;
	logic [2:0] cache_mode;
	logic [array_pkg::BLOCK_NO_W-1:0] cache_block_no;
	logic [array_pkg::WORD_IDX_W-1:0] cache_offset;
	logic [1:0] cache_in_select;
	logic exists;
	logic sd_start;
	logic sd_mode;
	logic [array_pkg::BLOCK_NO_W-1:0] sd_block_no;
	logic sd_read_enable;
	logic sd_write_enable;
	logic sd_ready;
	logic [array_pkg::SD_ERR_W-1:0] sd_error;
	logic [array_pkg::BLOCK_NO_W-1:0] cached_block;
	logic [array_pkg::SD_ERR_W-1:0] err_code;

	cmd_t cmds [N_ROWS];
	int cycles;

	array_ctrl_top dut0 (.*);
	sd_card_model card0 (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles > LIMIT) begin
				$display("timeout after %0d cycles, the DUT stopped answering", cycles);
				$display("Regression failed");
				$fatal(1);
			end
		end
	end

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want) begin
			$display("[ERROR] %s got 0x%0h, expected 0x%0h at %0t", name, got, want, $time);
			$display("Regression failed");
			$fatal(1);
		end
	endtask

	task automatic issue_command(input cmd_t c);
		@(posedge clk);
		cached_block <= c.miss ? ~c.blk : c.blk;
		err_code <= c.err;
		op_code <= c.op;
		ahb_block_no <= c.blk;
		mode <= c.rd;
		ahb_length <= c.len;
		ahb_offset <= c.off;
		ahb_ready <= 1'b1;
		@(posedge clk);
		ahb_ready <= 1'b0;
		@(negedge clk);
		compare_value("status", 32'(status), 32'(0));	// accept drops the old status
		@(negedge clk);	// decode is over here
	endtask

	task automatic host_burst(input cmd_t c);
		logic [array_pkg::WORD_IDX_W-1:0] want_off;
		for (int k = 0; k <= int'(c.len); k++) begin
			want_off = c.off + array_pkg::WORD_IDX_W'(k);	// wraps inside the block
			@(posedge clk);
			ahb_start <= 1'b1;
			@(negedge clk);
			compare_value("ahb_done", 32'(ahb_done), 32'(0));
			@(posedge clk);
			ahb_start <= 1'b0;
			@(negedge clk);
			compare_value("ahb_done", 32'(ahb_done), 32'(1));
			compare_value("cache_mode", 32'(cache_mode),
				32'(c.rd ? array_pkg::CACHE_READ : array_pkg::CACHE_WRITE));
			compare_value("cache_offset", 32'(cache_offset), 32'(want_off));
			compare_value("cache_in_select", 32'(cache_in_select), 32'(array_pkg::SEL_HOST));
			compare_value("cache_block_no", 32'(cache_block_no), 32'(c.blk));
			compare_value("status", 32'(status), 32'({6'd0, c.kind}));
		end
		@(negedge clk);
		compare_value("ahb_done", 32'(ahb_done), 32'(0));
		@(negedge clk);
		compare_value("status", 32'(status), 32'(0));	// session closed
		// one more start after the burst gets no done
		@(posedge clk);
		ahb_start <= 1'b1;
		@(posedge clk);
		ahb_start <= 1'b0;
		@(negedge clk);
		compare_value("ahb_done", 32'(ahb_done), 32'(0));
	endtask

	task automatic watch_fetch(input cmd_t c);
		int words;
		words = 0;
		while (words < array_pkg::BLOCK_WORDS) begin
			@(negedge clk);
			compare_value("sd_write_enable", 32'(sd_write_enable), 32'(0));
			compare_value("status", 32'(status), 32'(0));
			if (sd_read_enable) begin
				compare_value("sd_mode", 32'(sd_mode), 32'(0));
				compare_value("sd_block_no", 32'(sd_block_no), 32'(c.blk));
				compare_value("cache_mode", 32'(cache_mode), 32'(array_pkg::CACHE_WRITE));
				compare_value("cache_in_select", 32'(cache_in_select), 32'(array_pkg::SEL_SD));
				compare_value("cache_offset", 32'(cache_offset), 32'(words));
				words++;
			end
		end
		@(negedge clk);
		compare_value("status", 32'(status), 32'({6'd0, c.kind}));
	endtask

	task automatic watch_error(input cmd_t c);
		do begin
			@(negedge clk);
			compare_value("sd_read_enable", 32'(sd_read_enable), 32'(0));
		end while (status == '0);
		compare_value("status", 32'(status), 32'({c.err, c.kind}));
	endtask

	task automatic watch_sweep();
		int words;
		words = 0;
		while (words < array_pkg::CLEAR_BLOCKS * array_pkg::BLOCK_WORDS) begin
			@(negedge clk);
			compare_value("sd_read_enable", 32'(sd_read_enable), 32'(0));
			if (sd_write_enable) begin
				compare_value("sd_mode", 32'(sd_mode), 32'(1));
				compare_value("sd_block_no", 32'(sd_block_no), 32'(words / array_pkg::BLOCK_WORDS));
				compare_value("cache_in_select", 32'(cache_in_select), 32'(array_pkg::SEL_ZERO));
				words++;
			end
		end
	endtask

	task automatic run_command(input cmd_t c);
		logic [array_pkg::SD_ERR_W+2:0] final_status;
		final_status = {c.err, c.kind};
		issue_command(c);
		if (c.op == array_pkg::OP_ACCESS) begin
			if (c.err != '0) begin
				watch_error(c);
			end else begin
				final_status = '0;
				if (c.miss)
					watch_fetch(c);
				else
					compare_value("status", 32'(status), 32'({6'd0, c.kind}));
				host_burst(c);
			end
		end else if (c.op == array_pkg::OP_CLEAR_ALL) begin
			watch_sweep();
		end else begin
			compare_value("status", 32'(status), 32'(final_status));	// wrong op
		end
		repeat (4) begin
			@(negedge clk);
			compare_value("status", 32'(status), 32'(final_status));
			compare_value("sd_start", 32'(sd_start), 32'(0));
			compare_value("ahb_done", 32'(ahb_done), 32'(0));
			compare_value("sd_write_enable", 32'(sd_write_enable), 32'(0));
			compare_value("cache_mode", 32'(cache_mode), 32'(array_pkg::CACHE_IDLE));
		end
	endtask

	initial begin
		n_rst = 1'b0;
		ahb_ready = 1'b0;
		op_code = '0;
		ahb_block_no = '0;
		mode = 1'b0;
		ahb_length = '0;
		ahb_offset = '0;
		ahb_start = 1'b0;
		cached_block = '1;
		err_code = '0;

		// op, block, read, length, offset, miss, error, kind
		cmds[0] = '{3'd0, 32'h10, 1'b1, 7'd3, 7'd5, 1'b0, 6'd0, array_pkg::ST_READY};
		cmds[1] = '{3'd0, 32'h22, 1'b0, 7'd4, 7'd125, 1'b0, 6'd0, array_pkg::ST_READY};
		cmds[2] = '{3'd0, 32'h1234, 1'b1, 7'd2, 7'd0, 1'b1, 6'd0, array_pkg::ST_READY};
		cmds[3] = '{3'd0, 32'h40, 1'b0, 7'd1, 7'd64, 1'b1, 6'd0, array_pkg::ST_READY};
		cmds[4] = '{3'd0, 32'h77, 1'b1, 7'd0, 7'd0, 1'b1, 6'h2a, array_pkg::ST_SD_ERROR};
		cmds[5] = '{3'd3, 32'h0, 1'b0, 7'd0, 7'd0, 1'b0, 6'd0, array_pkg::ST_WRONG_OP};
		cmds[6] = '{3'd1, 32'h0, 1'b0, 7'd0, 7'd0, 1'b0, 6'd0, 3'b000};
		cmds[7] = '{3'd7, 32'h3, 1'b1, 7'd0, 7'd0, 1'b0, 6'd0, array_pkg::ST_WRONG_OP};
		cmds[8] = '{3'd0, 32'h9, 1'b0, 7'd2, 7'd9, 1'b1, 6'h01, array_pkg::ST_SD_ERROR};
		cmds[9] = '{3'd0, 32'h5, 1'b1, 7'd7, 7'd120, 1'b0, 6'd0, array_pkg::ST_READY};
		cmds[10] = '{3'd2, 32'h5, 1'b0, 7'd0, 7'd0, 1'b0, 6'd0, array_pkg::ST_WRONG_OP};

		repeat (7) @(posedge clk);
		@(negedge clk);
		compare_value("status", 32'(status), 32'(0));
		compare_value("ahb_done", 32'(ahb_done), 32'(0));
		compare_value("sd_start", 32'(sd_start), 32'(0));
		compare_value("sd_read_enable", 32'(sd_read_enable), 32'(0));
		compare_value("sd_write_enable", 32'(sd_write_enable), 32'(0));
		compare_value("cache_mode", 32'(cache_mode), 32'(array_pkg::CACHE_IDLE));
		@(posedge clk);
		n_rst <= 1'b1;	// eighth edge ends reset

		for (int i = 0; i < N_ROWS; i++)
			run_command(cmds[i]);

		repeat (2) @(posedge clk);
		$display("Regression passed");
		$finish;
	end

endmodule

//--- sim/sd_card_model.sv
`timescale 1ns/1ps

module sd_card_model (
	input  logic clk,
	input  logic n_rst,
	input  logic sd_start,
	input  logic sd_read_enable,
	input  logic sd_write_enable,
	input  logic [array_pkg::BLOCK_NO_W-1:0] cache_block_no,
	input  logic [array_pkg::BLOCK_NO_W-1:0] cached_block,	// the one block the tags hold
	input  logic [array_pkg::SD_ERR_W-1:0] err_code,	// nonzero makes the card refuse
	output logic exists,
	output logic sd_ready,
	output logic [array_pkg::SD_ERR_W-1:0] sd_error
);

	localparam logic [1:0] PH_IDLE = 2'd0;
	localparam logic [1:0] PH_WAIT = 2'd1;
	localparam logic [1:0] PH_ERR = 2'd2;
	localparam logic [1:0] PH_MOVE = 2'd3;

	logic [1:0] phase;
	logic [31:0] lfsr;
	int wait_cnt;
	int words;

	assign exists = cache_block_no == cached_block;

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	task automatic draw_bits(input int n, output int v);
		v = 0;
		for (int b = 0; b < n; b++) begin
			v = (v << 1) | int'(lfsr[0]);
			lfsr = lfsr_step(lfsr);	// one step per bit
		end
	endtask

	always @(posedge clk, negedge n_rst) begin
		int n_draw;
		if (!n_rst) begin
			phase <= PH_IDLE;
			sd_ready <= 1'b0;
			sd_error <= '0;
			wait_cnt <= 0;
			words <= 0;
			lfsr = 32'hfc14;
		end else begin
			case (phase)
			PH_IDLE: begin
				if (sd_start) begin
					draw_bits(3, n_draw);	// start latency 0 to 7
					wait_cnt <= n_draw;
					phase <= PH_WAIT;
				end
			end
			PH_WAIT: begin
				if (wait_cnt != 0) begin
					wait_cnt <= wait_cnt - 1;
				end else if (err_code != '0) begin
					sd_error <= err_code;
					phase <= PH_ERR;
				end else begin
					sd_ready <= 1'b1;	// accept, first word comes after
					words <= 0;
					phase <= PH_MOVE;
				end
			end
			PH_ERR: begin
				sd_error <= '0;
				phase <= PH_IDLE;
			end
			PH_MOVE: begin
				if (sd_ready) begin
					if ((sd_read_enable || sd_write_enable) &&
						words == array_pkg::BLOCK_WORDS - 1) begin
						sd_ready <= 1'b0;	// block complete
						phase <= PH_IDLE;
					end else begin
						if (sd_read_enable || sd_write_enable)
							words <= words + 1;
						draw_bits(2, n_draw);	// gap of 0 to 3 cycles
						if (n_draw != 0) begin
							sd_ready <= 1'b0;
							wait_cnt <= n_draw - 1;
						end
					end
				end else if (wait_cnt != 0) begin
					wait_cnt <= wait_cnt - 1;
				end else begin
					sd_ready <= 1'b1;
				end
			end
			endcase
		end
	end

endmodule

//--- logic/array_ctrl_top.sv
`timescale 1ns/1ps

module array_ctrl_top (
	input  logic clk,
	input  logic n_rst,

	// host command side
	input  logic ahb_ready,
	input  logic [2:0] op_code,
	input  logic [array_pkg::BLOCK_NO_W-1:0] ahb_block_no,
	input  logic mode,	// 1 = read
	input  logic [array_pkg::WORD_IDX_W-1:0] ahb_length,
	input  logic [array_pkg::WORD_IDX_W-1:0] ahb_offset,
	input  logic ahb_start,
	output logic ahb_done,
	output logic [array_pkg::SD_ERR_W+2:0] status,

	// cache side
	output logic [2:0] cache_mode,
	output logic [array_pkg::BLOCK_NO_W-1:0] cache_block_no,
	output logic [array_pkg::WORD_IDX_W-1:0] cache_offset,
	output logic [1:0] cache_in_select,
	input  logic exists,

	// sd side
	output logic sd_start,
	output logic sd_mode,	// 1 = write
	output logic [array_pkg::BLOCK_NO_W-1:0] sd_block_no,
	output logic sd_read_enable,
	output logic sd_write_enable,
	input  logic sd_ready,
	input  logic [array_pkg::SD_ERR_W-1:0] sd_error
);

	array_pkg::status_t status_word;

	logic session_start;
	logic session_over;
	logic [array_pkg::WORD_IDX_W-1:0] host_offset;
	logic [2:0] host_mode;

	logic xfer_start;
	logic xfer_write;
	logic xfer_done;
	logic xfer_error;
	logic [array_pkg::WORD_IDX_W-1:0] word_idx;

	logic sweep_clear;
	logic sweep_step;
	logic sweep_active;
	logic sweep_over;
	logic [array_pkg::BLOCK_NO_W-1:0] sweep_block_no;

	assign status = status_word.raw;

	// clear all addresses the sd by sweep count, everything else by host block
	assign sd_block_no = sweep_active ? sweep_block_no : ahb_block_no;

	cmd_sequencer seq0 (
		.clk(clk), .n_rst(n_rst),
		.ahb_ready(ahb_ready), .op_code(op_code), .ahb_block_no(ahb_block_no),
		.exists(exists), .session_over(session_over),
		.host_offset(host_offset), .host_mode(host_mode),
		.xfer_done(xfer_done), .xfer_error(xfer_error), .sd_error(sd_error),
		.word_idx(word_idx), .sweep_over(sweep_over),
		.status(status_word),
		.cache_mode(cache_mode), .cache_block_no(cache_block_no),
		.cache_offset(cache_offset), .cache_in_select(cache_in_select),
		.session_start(session_start), .xfer_start(xfer_start), .xfer_write(xfer_write),
		.sweep_clear(sweep_clear), .sweep_step(sweep_step), .sweep_active(sweep_active)
	);

	host_session host0 (
		.clk(clk), .n_rst(n_rst),
		.session_start(session_start), .ahb_start(ahb_start), .mode(mode),
		.ahb_length(ahb_length), .ahb_offset(ahb_offset),
		.ahb_done(ahb_done), .host_offset(host_offset), .host_mode(host_mode),
		.session_over(session_over)
	);

	sd_transfer sd0 (
		.clk(clk), .n_rst(n_rst),
		.xfer_start(xfer_start), .xfer_write(xfer_write),
		.sd_ready(sd_ready), .sd_error(sd_error),
		.sd_start(sd_start), .sd_mode(sd_mode),
		.sd_read_enable(sd_read_enable), .sd_write_enable(sd_write_enable),
		.word_idx(word_idx), .xfer_done(xfer_done), .xfer_error(xfer_error)
	);

	block_walker walk0 (
		.clk(clk), .n_rst(n_rst),
		.sweep_clear(sweep_clear), .sweep_step(sweep_step),
		.sweep_block_no(sweep_block_no), .sweep_over(sweep_over)
	);

endmodule

//--- logic/cmd_sequencer.sv
`timescale 1ns/1ps

module cmd_sequencer (
	input  logic clk,
	input  logic n_rst,
	input  logic ahb_ready,
	input  logic [2:0] op_code,
	input  logic [array_pkg::BLOCK_NO_W-1:0] ahb_block_no,
	input  logic exists,
	input  logic session_over,
	input  logic [array_pkg::WORD_IDX_W-1:0] host_offset,
	input  logic [2:0] host_mode,
	input  logic xfer_done,
	input  logic xfer_error,
	input  logic [array_pkg::SD_ERR_W-1:0] sd_error,
	input  logic [array_pkg::WORD_IDX_W-1:0] word_idx,
	input  logic sweep_over,
	output array_pkg::status_t status,
	output logic [2:0] cache_mode,
	output logic [array_pkg::BLOCK_NO_W-1:0] cache_block_no,
	output logic [array_pkg::WORD_IDX_W-1:0] cache_offset,
	output logic [1:0] cache_in_select,
	output logic session_start,
	output logic xfer_start,
	output logic xfer_write,
	output logic sweep_clear,
	output logic sweep_step,
	output logic sweep_active
);

	logic [2:0] state;
	logic [2:0] state_next;
	array_pkg::status_t status_next;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state <= array_pkg::SEQ_IDLE;
			status <= '0;
		end else begin
			state <= state_next;
			status <= status_next;
		end
	end

	always_comb begin
		state_next = state;
		status_next = status;	// held so an error survives in idle
		cache_mode = array_pkg::CACHE_IDLE;
		cache_block_no = '0;
		cache_offset = '0;
		cache_in_select = array_pkg::SEL_ZERO;	// also the zero data of the sweep
		session_start = 1'b0;
		xfer_start = 1'b0;
		xfer_write = 1'b0;
		sweep_clear = 1'b0;
		sweep_step = 1'b0;
		sweep_active = 1'b0;

		case (state)
		array_pkg::SEQ_IDLE: begin
			if (ahb_ready) begin
				status_next.raw = '0;	// new command drops old status
				state_next = array_pkg::SEQ_DECODE;
			end
		end

		// op decode and tag lookup in the same cycle
		array_pkg::SEQ_DECODE: begin
			cache_block_no = ahb_block_no;
			if (op_code == array_pkg::OP_ACCESS) begin
				if (exists) begin
					session_start = 1'b1;
					status_next.f.sd_err = '0;
					status_next.f.kind = array_pkg::ST_READY;
					state_next = array_pkg::SEQ_SESSION;
				end else begin
					xfer_start = 1'b1;	// miss fetches the block from sd
					state_next = array_pkg::SEQ_FETCH;
				end
			end else if (op_code == array_pkg::OP_CLEAR_ALL) begin
				state_next = array_pkg::SEQ_SWEEP_INIT;
			end else begin
				status_next.f.sd_err = '0;
				status_next.f.kind = array_pkg::ST_WRONG_OP;
				state_next = array_pkg::SEQ_IDLE;
			end
		end

		// miss fill overwrites the cache line word by word
		array_pkg::SEQ_FETCH: begin
			cache_block_no = ahb_block_no;
			cache_mode = array_pkg::CACHE_WRITE;
			cache_in_select = array_pkg::SEL_SD;
			cache_offset = word_idx;
			if (xfer_error) begin
				status_next.f.sd_err = sd_error;
				status_next.f.kind = array_pkg::ST_SD_ERROR;
				state_next = array_pkg::SEQ_IDLE;
			end else if (xfer_done) begin
				session_start = 1'b1;
				status_next.f.sd_err = '0;
				status_next.f.kind = array_pkg::ST_READY;
				state_next = array_pkg::SEQ_SESSION;
			end
		end

		array_pkg::SEQ_SESSION: begin
			cache_block_no = ahb_block_no;
			cache_mode = host_mode;	// idle between words
			cache_offset = host_offset;
			cache_in_select = array_pkg::SEL_HOST;
			if (session_over) begin
				status_next.raw = '0;
				state_next = array_pkg::SEQ_IDLE;
			end
		end

		array_pkg::SEQ_SWEEP_INIT: begin
			sweep_active = 1'b1;
			sweep_clear = 1'b1;
			cache_mode = array_pkg::CACHE_ZERO;
			state_next = array_pkg::SEQ_SWEEP_CHECK;
		end

		array_pkg::SEQ_SWEEP_CHECK: begin
			sweep_active = 1'b1;
			if (sweep_over) begin
				state_next = array_pkg::SEQ_IDLE;
			end else begin
				xfer_start = 1'b1;
				xfer_write = 1'b1;
				state_next = array_pkg::SEQ_SWEEP_XFER;
			end
		end

		array_pkg::SEQ_SWEEP_XFER: begin
			sweep_active = 1'b1;
			if (xfer_error) begin
				status_next.f.sd_err = sd_error;
				status_next.f.kind = array_pkg::ST_SD_ERROR;
				state_next = array_pkg::SEQ_IDLE;
			end else if (xfer_done) begin
				sweep_step = 1'b1;
				state_next = array_pkg::SEQ_SWEEP_CHECK;
			end
		end

		default: begin
			state_next = array_pkg::SEQ_IDLE;
		end
		endcase
	end

endmodule

//--- logic/block_walker.sv
`timescale 1ns/1ps

module block_walker (
	input  logic clk,
	input  logic n_rst,
	input  logic sweep_clear,
	input  logic sweep_step,
	output logic [array_pkg::BLOCK_NO_W-1:0] sweep_block_no,
	output logic sweep_over
);

	logic [array_pkg::SWEEP_W-1:0] blk;

	assign sweep_block_no = {{(array_pkg::BLOCK_NO_W - array_pkg::SWEEP_W){1'b0}}, blk};

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			blk <= '0;
			sweep_over <= 1'b0;
		end else if (sweep_clear) begin
			blk <= '0;
			sweep_over <= 1'b0;
		end else if (sweep_step) begin
			// last block written, roll over and flag the end
			if (blk == array_pkg::SWEEP_W'(array_pkg::CLEAR_BLOCKS - 1)) begin
				blk <= '0;
				sweep_over <= 1'b1;
			end else begin
				blk <= blk + 1'b1;
			end
		end
	end

endmodule

//--- logic/sd_transfer.sv
`timescale 1ns/1ps

module sd_transfer (
	input  logic clk,
	input  logic n_rst,
	input  logic xfer_start,
	input  logic xfer_write,
	input  logic sd_ready,
	input  logic [array_pkg::SD_ERR_W-1:0] sd_error,
	output logic sd_start,
	output logic sd_mode,
	output logic sd_read_enable,
	output logic sd_write_enable,
	output logic [array_pkg::WORD_IDX_W-1:0] word_idx,
	output logic xfer_done,
	output logic xfer_error
);

	logic starting;	// waiting for the card to accept
	logic moving;
	logic write_r;
	logic last_word;

	assign sd_start = starting;
	assign sd_mode = write_r;

	// one word per sd_ready cycle
	assign sd_read_enable = moving && sd_ready && !write_r;
	assign sd_write_enable = moving && sd_ready && write_r;

	assign last_word = word_idx == array_pkg::WORD_IDX_W'(array_pkg::BLOCK_WORDS - 1);
	assign xfer_done = moving && sd_ready && last_word;
	assign xfer_error = starting && !sd_ready && (sd_error != '0);

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			starting <= 1'b0;
			moving <= 1'b0;
			write_r <= 1'b0;
			word_idx <= '0;
		end else begin
			if (xfer_start) begin
				starting <= 1'b1;
				write_r <= xfer_write;
			end else if (starting && (sd_ready || sd_error != '0)) begin
				starting <= 1'b0;
			end

			if (starting && sd_ready) begin
				moving <= 1'b1;
				word_idx <= '0;
			end else if (moving && sd_ready) begin
				word_idx <= word_idx + 1'b1;	// wraps to 0 after the last word
				if (last_word)
					moving <= 1'b0;
			end
		end
	end

endmodule

//--- logic/host_session.sv
`timescale 1ns/1ps

module host_session (
	input  logic clk,
	input  logic n_rst,
	input  logic session_start,
	input  logic ahb_start,
	input  logic mode,	// 1 = read
	input  logic [array_pkg::WORD_IDX_W-1:0] ahb_length,
	input  logic [array_pkg::WORD_IDX_W-1:0] ahb_offset,
	output logic ahb_done,
	output logic [array_pkg::WORD_IDX_W-1:0] host_offset,
	output logic [2:0] host_mode,
	output logic session_over
);

	logic active;
	logic [array_pkg::WORD_IDX_W:0] served;	// one wider, length+1 reaches 128

	// burst is ahb_length+1 words
	assign session_over = active && !ahb_done &&
		(served == {1'b0, ahb_length} + 1'b1);

	assign host_offset = ahb_offset + served[array_pkg::WORD_IDX_W-1:0];

	// cache access happens in the done cycle only
	always_comb begin
		if (!ahb_done)
			host_mode = array_pkg::CACHE_IDLE;
		else if (mode)
			host_mode = array_pkg::CACHE_READ;
		else
			host_mode = array_pkg::CACHE_WRITE;
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			active <= 1'b0;
			served <= '0;
			ahb_done <= 1'b0;
		end else begin
			// start in the done cycle is dropped
			ahb_done <= active && ahb_start && !ahb_done && !session_over;

			if (session_start)
				active <= 1'b1;
			else if (session_over)
				active <= 1'b0;

			if (session_start)
				served <= '0;
			else if (ahb_done)
				served <= served + 1'b1;
		end
	end

endmodule

//--- logic/array_pkg.sv
package array_pkg;

	// block geometry
	localparam int BLOCK_WORDS = 128;
	localparam int WORD_IDX_W = 7;	// log2 of BLOCK_WORDS
	localparam int BLOCK_NO_W = 32;
	localparam int SD_ERR_W = 6;

	localparam int CLEAR_BLOCKS = 8;	// blocks zeroed by clear all
	localparam int SWEEP_W = $clog2(CLEAR_BLOCKS);

	// host op codes
	localparam logic [2:0] OP_ACCESS = 3'd0;
	localparam logic [2:0] OP_CLEAR_ALL = 3'd1;

	// cache port modes
	localparam logic [2:0] CACHE_IDLE = 3'b000;
	localparam logic [2:0] CACHE_WRITE = 3'b010;
	localparam logic [2:0] CACHE_READ = 3'b011;
	localparam logic [2:0] CACHE_ZERO = 3'b111;	// wipe whole cache

	// cache write data source
	localparam logic [1:0] SEL_ZERO = 2'd0;
	localparam logic [1:0] SEL_HOST = 2'd1;
	localparam logic [1:0] SEL_SD = 2'd2;

	// status kinds in the low bits of the status word
	localparam logic [2:0] ST_SD_ERROR = 3'b000;
	localparam logic [2:0] ST_WRONG_OP = 3'b100;
	localparam logic [2:0] ST_READY = 3'b001;

	// sequencer state codes
	localparam logic [2:0] SEQ_IDLE = 3'd0;
	localparam logic [2:0] SEQ_DECODE = 3'd1;
	localparam logic [2:0] SEQ_FETCH = 3'd2;
	localparam logic [2:0] SEQ_SESSION = 3'd3;
	localparam logic [2:0] SEQ_SWEEP_INIT = 3'd4;
	localparam logic [2:0] SEQ_SWEEP_CHECK = 3'd5;
	localparam logic [2:0] SEQ_SWEEP_XFER = 3'd6;

	// host sees raw, the sequencer fills in the fields
	typedef union packed {
		logic [SD_ERR_W+2:0] raw;
		struct packed {
			logic [SD_ERR_W-1:0] sd_err;
			logic [2:0] kind;
		} f;
	} status_t;

endpackage
